// ==== cx4_cart_defs.svh ====
`ifndef CX4_CART_DEFS_SVH
`define CX4_CART_DEFS_SVH

// Feature bit numbers in cfg.featurebits
`define FEAT_MSU1 3
`define FEAT_213F 4

// Cx4 register window of 128 bytes mirrored over 6000-7FFF
`define MMIO_WIN_BITS 7
`define MMIO_VEC_BASE 8'h60   // Vector bytes 60-7F
`define MMIO_VEC_CTRL 8'h5F   // Bit 0 = vector override

// 64 byte command buffer mirrored over 2A00-2BFF
`define SNESCMD_BITS 6

// Nothing decoded
`define OPEN_BUS_VAL 8'h00

// ROM model depth in address bits
`define ROM_BITS 16

`endif

// ==== cx4_cart_pkg.sv ====
`include "cx4_cart_defs.svh"

package cx4_cart_pkg;

  // Decoded access target
  typedef enum logic [2:0] {
    tgt_none,
    tgt_rom,
    tgt_mmio,
    tgt_vect,     // Cx4 vector override
    tgt_msu,
    tgt_snescmd,
    tgt_r213f
  } target_e;

  // Wishbone slave states
  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_ack
  } bus_state_e;

  typedef struct packed {
    logic [7:0]  featurebits;
    logic [23:0] rom_mask;
    logic        region;       // 1 = PAL
  } cart_cfg_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic        bbus;         // Peripheral address in adr[7:0]
    logic [23:0] adr;
    logic [7:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    target_e                   target;
    logic [23:0]               rom_addr;
    logic                      is_rom;
    logic                      is_writable;
    logic [`MMIO_WIN_BITS-1:0] off;   // Local offset in target
  } decode_t;

  // One-cycle access to a register target
  typedef struct packed {
    logic                      en;
    logic                      we;
    logic [`MMIO_WIN_BITS-1:0] off;
    logic [7:0]                dat;
  } tgt_acc_t;

  // MCU side ROM load port
  typedef struct packed {
    logic        we;
    logic [23:0] adr;
    logic [7:0]  dat;
  } mcu_wr_t;

endpackage

// ==== cx4_addr_decode.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module cx4_addr_decode
  import cx4_cart_pkg::*;
(
  input  logic [23:0] req_adr,       // Latched SNES address
  input  logic        bbus,          // B-bus access
  input  cart_cfg_t   cfg,
  input  logic        vec_override,  // From Cx4 control byte
  output decode_t     dec
);

  logic [15:0] a16;   // Address within bank
  logic        a22;
  logic        hit_msu, hit_cmd, hit_mmio, hit_vect, hit_rom, hit_213f;

  assign a16 = req_adr[15:0];
  assign a22 = req_adr[22];   // a23 ignored so 80-FF mirror 00-7F

  ////////////////////
  // Window hits
  ////////////////////
  assign hit_msu  = cfg.featurebits[`FEAT_MSU1] & !a22 & ((a16 & 16'hfff8) == 16'h2000);
  assign hit_cmd  = ({a22, a16[15:9]} == 8'b0_0010101);   // 2A00-2BFF
  assign hit_mmio = !a22 & (a16[15:13] == 3'b011);        // 6000-7FFF
  assign hit_vect = !a22 & (&a16[15:5]) & vec_override;   // FFE0-FFFF
  assign hit_rom  = a16[15] | a22;
  assign hit_213f = cfg.featurebits[`FEAT_213F] & (req_adr[7:0] == 8'h3f);

  // LoROM drops a15 and a23 before the mask
  assign dec.rom_addr = {2'b00, req_adr[22:16], req_adr[14:0]} & cfg.rom_mask;
  assign dec.is_rom   = hit_rom & !bbus;

  ////////////////////
  // Priority select
  ////////////////////
  always_comb begin
    dec.target      = tgt_none;
    dec.off         = '0;
    dec.is_writable = 1'b0;
    if (bbus) begin
      if (hit_213f) begin
        dec.target = tgt_r213f;   // Read only
      end
    end else if (hit_msu) begin
      dec.target      = tgt_msu;
      dec.off         = {4'b0000, a16[2:0]};
      dec.is_writable = 1'b1;
    end else if (hit_cmd) begin
      dec.target      = tgt_snescmd;
      dec.off         = {1'b0, a16[`SNESCMD_BITS-1:0]};   // 64 byte mirror
      dec.is_writable = 1'b1;
    end else if (hit_mmio) begin
      dec.target      = tgt_mmio;
      dec.off         = a16[`MMIO_WIN_BITS-1:0];          // 128 byte mirror
      dec.is_writable = 1'b1;
    end else if (hit_vect) begin
      dec.target = tgt_vect;
      dec.off    = {2'b00, a16[4:0]};   // Vector index
    end else if (hit_rom) begin
      dec.target = tgt_rom;   // Never writable from SNES
    end
  end

endmodule

// ==== cx4_rom.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module cx4_rom
  import cx4_cart_pkg::*;
(
  input  logic        clk,
  input  mcu_wr_t     mcu,       // Load port
  input  logic        rd_en,
  input  logic [23:0] rd_addr,   // Masked LoROM address
  output logic [7:0]  rd_dat
);

  logic [7:0] mem [0:(1 << `ROM_BITS) - 1];

  ////////////////////
  // MCU load
  ////////////////////
  always_ff @(posedge clk) begin
    if (mcu.we) begin
      mem[mcu.adr[`ROM_BITS-1:0]] <= mcu.dat;   // Upper bits dropped
    end
  end

  ////////////////////
  // SNES read
  ////////////////////
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_dat <= mem[rd_addr[`ROM_BITS-1:0]];   // Data one cycle after enable
    end
  end

endmodule

// ==== cx4_mmio.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module cx4_mmio
  import cx4_cart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  tgt_acc_t   acc,
  input  logic       vec_sel,        // Vector read by vector index
  output logic [7:0] rd_dat,
  output logic       vec_override
);

  localparam int WIN_SIZE = 1 << `MMIO_WIN_BITS;

  logic [7:0] regs [0:WIN_SIZE-1];
  logic [7:0] vec_idx;

  // Vector bytes sit at the top of the window
  assign vec_idx = `MMIO_VEC_BASE + {3'b000, acc.off[4:0]};

  ////////////////////
  // Register window
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < WIN_SIZE; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (acc.en && acc.we && !vec_sel) begin
      regs[acc.off] <= acc.dat;
    end
  end

  // Read port for vector or plain window
  always_ff @(posedge clk) begin
    if (acc.en) begin
      if (vec_sel) begin
        rd_dat <= regs[vec_idx[`MMIO_WIN_BITS-1:0]];
      end else begin
        rd_dat <= regs[acc.off];
      end
    end
  end

  assign vec_override = regs[7'(`MMIO_VEC_CTRL)][0];   // Control bit 0

endmodule

// ==== snes_aux_regs.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module snes_aux_regs
  import cx4_cart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  tgt_acc_t   acc,
  input  target_e    sel,      // Which aux target is addressed
  input  logic       region,
  output logic [7:0] rd_dat
);

  localparam int CMD_SIZE = 1 << `SNESCMD_BITS;

  logic [7:0] msu_regs [0:7];
  logic [7:0] cmd_buf  [0:CMD_SIZE-1];
  logic [7:0] r213f;

  assign r213f = {3'b000, region, 4'b0000};   // Region in bit 4

  ////////////////////
  // Storage
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        msu_regs[i] <= 8'h00;
      end
      for (int i = 0; i < CMD_SIZE; i++) begin
        cmd_buf[i] <= 8'h00;
      end
    end else if (acc.en && acc.we) begin
      if (sel == tgt_msu) begin
        msu_regs[acc.off[2:0]] <= acc.dat;
      end else if (sel == tgt_snescmd) begin
        cmd_buf[acc.off[`SNESCMD_BITS-1:0]] <= acc.dat;
      end
    end
  end

  // Read data one cycle after enable
  always_ff @(posedge clk) begin
    if (acc.en) begin
      case (sel)
        tgt_msu:     rd_dat <= msu_regs[acc.off[2:0]];
        tgt_snescmd: rd_dat <= cmd_buf[acc.off[`SNESCMD_BITS-1:0]];
        tgt_r213f:   rd_dat <= r213f;
        default:     rd_dat <= `OPEN_BUS_VAL;
      endcase
    end
  end

endmodule

// ==== cx4_cart_bus.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module cx4_cart_bus
  import cx4_cart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  wb_req_t     req,
  output wb_rsp_t     rsp,
  input  decode_t     dec,
  output logic [23:0] dec_adr,
  output logic        dec_bbus,
  output logic        rom_en,
  input  logic [7:0]  rom_dat,
  output tgt_acc_t    mmio_acc,
  output logic        vec_sel,
  input  logic [7:0]  mmio_dat,
  output tgt_acc_t    aux_acc,
  output target_e     aux_sel,
  input  logic [7:0]  aux_dat
);

  bus_state_e state;
  wb_req_t    req_q;     // Held for the whole access
  target_e    tgt_q;     // Target of the access in flight
  logic       in_access;
  logic       wr_ok;
  logic [7:0] rd_mux;

  assign dec_adr  = req_q.adr;
  assign dec_bbus = req_q.bbus;

  ////////////////////
  // Slave FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      req_q <= '0;
      tgt_q <= tgt_none;
      rsp   <= '0;
    end else begin
      rsp.ack <= 1'b0;   // Single cycle ack
      case (state)
        st_idle: begin
          // Ignore stb while the previous ack is still up
          if (req.cyc && req.stb && !rsp.ack) begin
            req_q <= req;
            state <= st_access;
          end
        end
        st_access: begin
          tgt_q <= dec.target;   // Target strobed this cycle
          state <= st_ack;
        end
        st_ack: begin
          rsp.ack <= 1'b1;
          rsp.dat <= rd_mux;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign in_access = (state == st_access) && req_q.cyc;
  assign wr_ok     = req_q.we && dec.is_writable;   // Drop writes to read only space

  ////////////////////
  // Target strobes
  ////////////////////
  assign rom_en  = in_access && dec.is_rom && (dec.target == tgt_rom);
  assign vec_sel = (dec.target == tgt_vect);
  assign aux_sel = dec.target;

  always_comb begin
    mmio_acc.en  = in_access && (dec.target inside {tgt_mmio, tgt_vect});
    mmio_acc.we  = wr_ok;
    mmio_acc.off = dec.off;
    mmio_acc.dat = req_q.dat;
    aux_acc.en   = in_access && (dec.target inside {tgt_msu, tgt_snescmd, tgt_r213f});
    aux_acc.we   = wr_ok;
    aux_acc.off  = dec.off;
    aux_acc.dat  = req_q.dat;
  end

  // Return data by latched target
  always_comb begin
    case (tgt_q)
      tgt_rom:                        rd_mux = rom_dat;
      tgt_mmio, tgt_vect:             rd_mux = mmio_dat;
      tgt_msu, tgt_snescmd, tgt_r213f: rd_mux = aux_dat;
      default:                        rd_mux = `OPEN_BUS_VAL;
    endcase
  end

endmodule

// ==== cx4_cart_top.sv ====
`timescale 1ns/10ps

module cx4_cart_top
  import cx4_cart_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  cart_cfg_t cfg,
  input  mcu_wr_t   mcu,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp
);

  decode_t     dec;
  logic [23:0] dec_adr;
  logic        dec_bbus;
  logic        rom_en;
  logic [7:0]  rom_dat;
  tgt_acc_t    mmio_acc;
  tgt_acc_t    aux_acc;
  logic        vec_sel;
  logic [7:0]  mmio_dat;
  target_e     aux_sel;
  logic [7:0]  aux_dat;
  logic        vec_override;   // Cx4 control bit back into decode

  cx4_cart_bus u_bus (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (wb_req),
    .rsp      (wb_rsp),
    .dec      (dec),
    .dec_adr  (dec_adr),
    .dec_bbus (dec_bbus),
    .rom_en   (rom_en),
    .rom_dat  (rom_dat),
    .mmio_acc (mmio_acc),
    .vec_sel  (vec_sel),
    .mmio_dat (mmio_dat),
    .aux_acc  (aux_acc),
    .aux_sel  (aux_sel),
    .aux_dat  (aux_dat)
  );

  cx4_addr_decode u_decode (
    .req_adr      (dec_adr),
    .bbus         (dec_bbus),
    .cfg          (cfg),
    .vec_override (vec_override),
    .dec          (dec)
  );

  cx4_rom u_rom (
    .clk     (clk),
    .mcu     (mcu),
    .rd_en   (rom_en),
    .rd_addr (dec.rom_addr),
    .rd_dat  (rom_dat)
  );

  cx4_mmio u_mmio (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc          (mmio_acc),
    .vec_sel      (vec_sel),
    .rd_dat       (mmio_dat),
    .vec_override (vec_override)
  );

  snes_aux_regs u_aux (
    .clk    (clk),
    .rst_n  (rst_n),
    .acc    (aux_acc),
    .sel    (aux_sel),
    .region (cfg.region),
    .rd_dat (aux_dat)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset low for 3 rising edges and released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== cx4_cart_tb.sv ====
`timescale 1ns/10ps
`include "cx4_cart_defs.svh"

module cx4_cart_tb
  import cx4_cart_pkg::*;
();

  localparam int N_LOADS    = 1 << `ROM_BITS;   // One MCU write per ROM byte
  localparam int N_ACCESSES = 600;              // Upper bound over all tests
  localparam int WD_CYCLES  = N_LOADS * 2 + N_ACCESSES * 200;

  logic      clk;
  logic      rst_n;
  cart_cfg_t cfg;
  mcu_wr_t   mcu;
  wb_req_t   req;
  wb_rsp_t   wb_rsp;
  target_e   last_tgt;        // Target latched by the DUT for the last access
  int        rsp_errs;
  int        tgt_errs;
  int        proto_errs;

  // Reference memories
  logic [7:0] rom_m  [0:N_LOADS-1];
  logic [7:0] mmio_m [0:127];
  logic [7:0] msu_m  [0:7];
  logic [7:0] cmd_m  [0:63];

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  cx4_cart_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg    (cfg),
    .mcu    (mcu),
    .wb_req (req),
    .wb_rsp (wb_rsp)
  );

  ////////////////////
  // Reference model
  ////////////////////
  function automatic target_e model_target(input logic bbus, input logic [23:0] adr);
    logic [15:0] a;
    logic        a22;
    a   = adr[15:0];
    a22 = adr[22];   // a23 never matters
    if (bbus) begin
      if (cfg.featurebits[`FEAT_213F] && adr[7:0] == 8'h3f) return tgt_r213f;
      return tgt_none;
    end
    if (cfg.featurebits[`FEAT_MSU1] && !a22 && a >= 16'h2000 && a <= 16'h2007) return tgt_msu;
    if (!a22 && a >= 16'h2a00 && a <= 16'h2bff) return tgt_snescmd;
    if (!a22 && a >= 16'h6000 && a <= 16'h7fff) return tgt_mmio;
    if (!a22 && a >= 16'hffe0 && mmio_m[int'(`MMIO_VEC_CTRL)][0]) return tgt_vect;
    if (a[15] || a22) return tgt_rom;
    return tgt_none;
  endfunction

  function automatic logic [7:0] model_read(input logic bbus, input logic [23:0] adr);
    logic [23:0] ra;
    ra = {2'b00, adr[22:16], adr[14:0]} & cfg.rom_mask;   // Masked LoROM
    case (model_target(bbus, adr))
      tgt_rom:     return rom_m[ra[15:0]];
      tgt_mmio:    return mmio_m[adr[6:0]];      // 128 byte mirror
      tgt_vect:    return mmio_m[int'(`MMIO_VEC_BASE) + int'(adr[4:0])];
      tgt_msu:     return msu_m[adr[2:0]];
      tgt_snescmd: return cmd_m[adr[5:0]];       // 64 byte mirror
      tgt_r213f:   return {3'b000, cfg.region, 4'b0000};
      default:     return `OPEN_BUS_VAL;
    endcase
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_rsp(input wb_rsp_t exp, input wb_rsp_t act);
    if (exp !== act) begin
      rsp_errs++;
      $display("ERR %0t wb_rsp exp=%h act=%h", $time, exp, act);
    end
  endtask

  task automatic check_target(input target_e exp, input target_e act);
    if (exp !== act) begin
      tgt_errs++;
      $display("ERR %0t tgt_q exp=%s act=%s", $time, exp.name(), act.name());
    end
  endtask

  ////////////////////
  // Bus driver
  ////////////////////
  // Starts and ends on a falling edge
  task automatic bus_access(input logic we, input logic bbus, input logic [23:0] adr,
                            input logic [7:0] dat, output wb_rsp_t got);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    req.cyc  = 1'b1;
    req.stb  = 1'b1;
    req.we   = we;
    req.bbus = bbus;
    req.adr  = adr;
    req.dat  = dat;
    while (!seen && n < 10) begin
      @(negedge clk);
      n++;
      if (wb_rsp.ack) begin
        seen     = 1'b1;
        last_tgt = uut.u_bus.tgt_q;
      end
    end
    got = wb_rsp;
    if (!seen) begin
      proto_errs++;
      $display("%0t: no ack within 10 cycles for access to %h", $time, adr);
    end else if (n != 3) begin
      proto_errs++;
      $display("%0t: ack came %0d cycles after the request instead of 3", $time, n);
    end
    req = '0;   // Drop cyc and stb
    @(negedge clk);
    if (wb_rsp.ack) begin
      proto_errs++;
      $display("%0t: ack stayed high for more than one cycle", $time);
    end
  endtask

  task automatic rd_byte(input logic bbus, input logic [23:0] adr);
    target_e exp_tgt;
    wb_rsp_t exp_rsp;
    wb_rsp_t got;
    exp_tgt     = model_target(bbus, adr);
    exp_rsp.ack = 1'b1;
    exp_rsp.dat = model_read(bbus, adr);
    bus_access(1'b0, bbus, adr, 8'h00, got);
    check_target(exp_tgt, last_tgt);
    check_rsp(exp_rsp, got);
  endtask

  task automatic wr_byte(input logic bbus, input logic [23:0] adr, input logic [7:0] dat);
    target_e exp_tgt;
    wb_rsp_t got;
    exp_tgt = model_target(bbus, adr);
    bus_access(1'b1, bbus, adr, dat, got);
    check_target(exp_tgt, last_tgt);
    case (exp_tgt)   // ROM, vector and none drop the write
      tgt_mmio:    mmio_m[adr[6:0]] = dat;
      tgt_msu:     msu_m[adr[2:0]]  = dat;
      tgt_snescmd: cmd_m[adr[5:0]]  = dat;
      default: ;
    endcase
  endtask

  // Only while cyc is low
  task automatic load_rom();
    for (int i = 0; i < N_LOADS; i++) begin
      mcu.we   = 1'b1;
      mcu.adr  = {8'($urandom), 16'(i)};   // Upper bits must be dropped
      mcu.dat  = 8'($urandom);
      rom_m[i] = mcu.dat;
      @(negedge clk);
    end
    mcu = '0;
  endtask

  function automatic logic [7:0] random_bank();
    logic [7:0] b;
    b = 8'($urandom_range(0, 255));
    if (b[6:1] == 6'h3f) b[6:0] = 7'h7d;   // WRAM banks and their mirrors
    return b;
  endfunction

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset();
    check_rsp('0, wb_rsp);   // ack low out of reset
    for (int i = 0; i < 8; i++) begin
      rd_byte(1'b0, 24'h006000 + 24'(i * 37));
    end
  endtask

  task automatic test_rom_map();
    logic [23:0] masks [3];
    logic [23:0] adr;
    masks = '{24'h00ffff, 24'h007fff, 24'h003fff};
    load_rom();
    foreach (masks[m]) begin
      cfg.rom_mask = masks[m];
      repeat (40) begin
        adr = {random_bank(), 1'b1, 15'($urandom)};
        rd_byte(1'b0, adr);
        rd_byte(1'b0, adr ^ 24'h800000);   // a23 mirror
      end
    end
    cfg.rom_mask = 24'hffffff;
    repeat (4) begin
      adr = {random_bank(), 1'b1, 15'($urandom)};
      wr_byte(1'b0, adr, ~model_read(1'b0, adr));   // Must not stick
      rd_byte(1'b0, adr);
    end
  endtask

  task automatic test_mmio();
    logic [23:0] adr;
    repeat (24) begin
      adr = {1'($urandom), 1'b0, 6'($urandom), 3'b011, 13'($urandom)};
      wr_byte(1'b0, adr, 8'($urandom));
      rd_byte(1'b0, adr);
      adr[23]   = ~adr[23];
      adr[12:7] = 6'($urandom);   // Other mirror of the same byte
      rd_byte(1'b0, adr);
    end
  endtask

  task automatic test_vector();
    wr_byte(1'b0, 24'h00605f, 8'h00);
    for (int i = 0; i < 32; i++) begin
      wr_byte(1'b0, 24'h006060 + 24'(i), 8'($urandom));
    end
    for (int i = 0; i < 8; i++) rd_byte(1'b0, 24'h00ffe0 + 24'(i * 4));   // Still ROM
    wr_byte(1'b0, 24'h017f5f, 8'h01);   // Override on through a mirror
    for (int i = 0; i < 32; i++) begin
      rd_byte(1'b0, 24'h00ffe0 + 24'(i));
      rd_byte(1'b0, 24'h80ffe0 + 24'(i));
    end
    rd_byte(1'b0, 24'h40ffe0);   // a22 set stays ROM
    wr_byte(1'b0, 24'h00605f, 8'h00);
    for (int i = 0; i < 8; i++) rd_byte(1'b0, 24'h00ffe3 + 24'(i * 4));
  endtask

  task automatic test_msu_213f();
    cfg.featurebits = 8'((1 << `FEAT_MSU1) | (1 << `FEAT_213F));
    cfg.region      = 1'b1;
    for (int i = 0; i < 8; i++) wr_byte(1'b0, 24'h002000 + 24'(i), 8'($urandom));
    for (int i = 0; i < 8; i++) rd_byte(1'b0, 24'h802000 + 24'(i));
    rd_byte(1'b1, 24'h00003f);
    rd_byte(1'b1, 24'h00003e);
    cfg.featurebits = 8'h00;   // Both windows gated off
    wr_byte(1'b0, 24'h002003, 8'hc3);
    for (int i = 0; i < 8; i++) rd_byte(1'b0, 24'h002000 + 24'(i));
    rd_byte(1'b1, 24'h00003f);
    cfg.featurebits = 8'((1 << `FEAT_MSU1) | (1 << `FEAT_213F));
    cfg.region      = 1'b0;
    rd_byte(1'b0, 24'h002003);
    rd_byte(1'b1, 24'h00003f);
  endtask

  task automatic test_cmd_unmapped();
    logic [23:0] adr;
    repeat (16) begin
      adr = {1'($urandom), 1'b0, 6'($urandom), 7'b0010101, 9'($urandom)};
      wr_byte(1'b0, adr, 8'($urandom));
      adr[8:6] = 3'($urandom);   // 64 byte mirror
      rd_byte(1'b0, adr);
    end
    rd_byte(1'b0, 24'h001000);
    wr_byte(1'b0, 24'h001000, 8'h5a);
    rd_byte(1'b0, 24'h001000);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    void'($urandom(32'hfcea));
    rsp_errs   = 0;
    tgt_errs   = 0;
    proto_errs = 0;
    last_tgt   = tgt_none;
    req        = '0;
    mcu        = '0;
    cfg        = '0;
    cfg.rom_mask = 24'hffffff;
    foreach (mmio_m[i]) mmio_m[i] = 8'h00;
    foreach (msu_m[i]) msu_m[i] = 8'h00;
    foreach (cmd_m[i]) cmd_m[i] = 8'h00;
    wait (rst_n === 1'b1);   // Released on a falling edge
    test_reset();
    test_rom_map();
    test_mmio();
    test_vector();
    test_msu_213f();
    test_cmd_unmapped();
    $display("errors: rsp=%0d target=%0d protocol=%0d", rsp_errs, tgt_errs, proto_errs);
    if (rsp_errs + tgt_errs + proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", WD_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== cx4_cart.f ====
+incdir+.
cx4_cart_pkg.sv
cx4_addr_decode.sv
cx4_rom.sv
cx4_mmio.sv
snes_aux_regs.sv
cx4_cart_bus.sv
cx4_cart_top.sv
tb_clock_gen.sv
cx4_cart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cx4_cart testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f cx4_cart.f --top-module cx4_cart_tb -o cx4_cart_sim

./obj_dir/cx4_cart_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run_sim: pass"
else
  echo "run_sim: fail"
  exit 1
fi
